/* shot_pkg.sv */
// shot handling package
// game mode, shot record types and the constants shared by the
// decode, scale, hit check and score stages

package shot_pkg;

    // data path widths
    localparam int POS_W   = 10;
    localparam int SCORE_W = 16;
    localparam int MISS_W  = 8;

    typedef enum logic {
        SOLO  = 1'b0,
        MULTI = 1'b1
    } g_mode;

    // captured or scaled shot
    typedef struct packed {
        logic [POS_W-1:0] xpos;
        logic [POS_W-1:0] ypos;
        g_mode            mode;
    } shot_t;

    // judged shot
    typedef struct packed {
        logic [POS_W-1:0] xpos;
        logic [POS_W-1:0] ypos;
        g_mode            mode;
        logic             hit;
    } hit_t;

    localparam logic [POS_W-1:0] SCREEN_H    = 10'd768;  // visible lines
    localparam logic [POS_W-1:0] TARGET_HALF = 10'd32;   // half side of target square

    localparam logic [SCORE_W-1:0] SOLO_POINTS  = 16'd10;
    localparam logic [SCORE_W-1:0] MULTI_POINTS = 16'd20;
    localparam logic [SCORE_W-1:0] SCORE_MAX    = 16'd65535;
    localparam logic [MISS_W-1:0]  MISS_MAX     = 8'd255;

    // multi mode x band edges, lower bound of each band
    localparam logic [POS_W-1:0] X_BRK_0    = 10'd155;
    localparam logic [POS_W-1:0] X_BRK_1    = 10'd255;
    localparam logic [POS_W-1:0] X_BRK_2    = 10'd355;
    localparam logic [POS_W-1:0] X_BRK_3    = 10'd669;
    localparam logic [POS_W-1:0] X_BRK_4    = 10'd769;
    localparam logic [POS_W-1:0] X_BRK_5    = 10'd869;
    localparam logic [POS_W-1:0] X_FAR_EDGE = 10'd1000;

    // multi mode y band edges
    localparam logic [POS_W-1:0] Y_BRK_0    = 10'd195;  // inclusive upper edge of the zero band
    localparam logic [POS_W-1:0] Y_BRK_1    = 10'd300;  // inclusive upper edge of the shifted band
    localparam logic [POS_W-1:0] Y_BRK_2    = 10'd450;
    localparam logic [POS_W-1:0] Y_BRK_3    = 10'd510;
    localparam logic [POS_W-1:0] Y_BRK_4    = 10'd550;
    localparam logic [POS_W-1:0] Y_FAR_EDGE = 10'd738;

    // band offsets
    localparam logic [POS_W-1:0] X_OFS_0 = 10'd120;  // subtracted
    localparam logic [POS_W-1:0] X_OFS_1 = 10'd100;  // subtracted
    localparam logic [POS_W-1:0] X_OFS_2 = 10'd50;   // subtracted
    localparam logic [POS_W-1:0] X_OFS_3 = 10'd20;   // added
    localparam logic [POS_W-1:0] Y_OFS_0 = 10'd85;   // subtracted
    localparam logic [POS_W-1:0] Y_OFS_1 = 10'd40;   // added

endpackage

/* shot_decode.sv */
// shot decode stage
// finds the rising edge of the click level, drops presses below
// the visible screen and captures position and mode of the press

`timescale 1ns/1ps

module shot_decode (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         click,
    input  logic [shot_pkg::POS_W-1:0]   mouse_xpos,
    input  logic [shot_pkg::POS_W-1:0]   mouse_ypos,
    input  shot_pkg::g_mode              game_mode,
    output logic                         cap_valid,
    output shot_pkg::shot_t              cap_shot
);

    logic click_q;  // click level from last edge
    logic press;
    logic on_screen;

    assign press     = click && !click_q;
    assign on_screen = (mouse_ypos < shot_pkg::SCREEN_H);

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            click_q   <= 1'b0;
            cap_valid <= 1'b0;
        end else begin
            click_q   <= click;
            cap_valid <= press && on_screen;
        end
    end

    // payload, sampled with the press so later mode changes
    // leave the shot alone
    always_ff @(posedge clk) begin
        cap_shot.xpos <= mouse_xpos;
        cap_shot.ypos <= mouse_ypos;
        cap_shot.mode <= game_mode;
    end

    // a press needs a low cycle before the next one
    property p_no_back_to_back;
        @(posedge clk) disable iff (rst)
        cap_valid |=> !cap_valid;
    endproperty

    a_no_back_to_back : assert property (p_no_back_to_back)
        else $error("cap_valid high on two consecutive cycles");

endmodule

/* shot_scale.sv */
// shot scale stage
// maps a captured shot into playfield coordinates
// solo shots pass through and multi shots get a piecewise rescale per axis
// the mode used is the one captured with the shot

`timescale 1ns/1ps

module shot_scale (
    input  logic            clk,
    input  logic            rst,
    input  logic            cap_valid,
    input  shot_pkg::shot_t cap_shot,
    output logic            scl_valid,
    output shot_pkg::shot_t scl_shot
);

    logic [shot_pkg::POS_W-1:0] x_multi;
    logic [shot_pkg::POS_W-1:0] y_multi;
    logic [shot_pkg::POS_W-1:0] x_nxt;
    logic [shot_pkg::POS_W-1:0] y_nxt;

    // x bands checked low to high
    always_comb begin
        if (cap_shot.xpos < shot_pkg::X_BRK_0) begin
            x_multi = '0;                                       // left margin
        end else if (cap_shot.xpos < shot_pkg::X_BRK_1) begin
            x_multi = cap_shot.xpos - shot_pkg::X_OFS_0;
        end else if (cap_shot.xpos < shot_pkg::X_BRK_2) begin
            x_multi = cap_shot.xpos - shot_pkg::X_OFS_1;
        end else if (cap_shot.xpos < shot_pkg::X_BRK_3) begin
            x_multi = cap_shot.xpos - shot_pkg::X_OFS_2;
        end else if (cap_shot.xpos < shot_pkg::X_BRK_4) begin
            x_multi = cap_shot.xpos;                            // centre band unchanged
        end else if (cap_shot.xpos < shot_pkg::X_BRK_5) begin
            x_multi = cap_shot.xpos + shot_pkg::X_OFS_3;
        end else begin
            x_multi = shot_pkg::X_FAR_EDGE;                     // clamp right side
        end
    end

    // y bands with inclusive first two edges
    always_comb begin
        if (cap_shot.ypos <= shot_pkg::Y_BRK_0) begin
            y_multi = '0;
        end else if (cap_shot.ypos <= shot_pkg::Y_BRK_1) begin
            y_multi = cap_shot.ypos - shot_pkg::Y_OFS_0;
        end else if (cap_shot.ypos < shot_pkg::Y_BRK_2) begin
            y_multi = cap_shot.ypos;
        end else if (cap_shot.ypos < shot_pkg::Y_BRK_3) begin
            y_multi = cap_shot.ypos + shot_pkg::Y_OFS_1;
        end else if (cap_shot.ypos < shot_pkg::Y_BRK_4) begin
            y_multi = shot_pkg::Y_BRK_4;                        // flat step
        end else begin
            y_multi = shot_pkg::Y_FAR_EDGE;
        end
    end

    // pick by the shot's own mode
    always_comb begin
        case (cap_shot.mode)
            shot_pkg::MULTI: begin
                x_nxt = x_multi;
                y_nxt = y_multi;
            end
            shot_pkg::SOLO: begin
                x_nxt = cap_shot.xpos;
                y_nxt = cap_shot.ypos;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            scl_valid <= 1'b0;
        end else begin
            scl_valid <= cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        scl_shot.xpos <= x_nxt;
        scl_shot.ypos <= y_nxt;
        scl_shot.mode <= cap_shot.mode;
    end

    // exactly one cycle through this stage
    property p_one_cycle_fwd;
        @(posedge clk) disable iff (rst)
        cap_valid |=> scl_valid;
    endproperty

    a_one_cycle_fwd : assert property (p_one_cycle_fwd)
        else $error("scl_valid missing one cycle after cap_valid");

endmodule

/* shot_hit_check.sv */
// shot hit check stage
// judges the scaled shot against a square target centred on the target position
// hit when both axis distances are within the half side

`timescale 1ns/1ps

module shot_hit_check (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         scl_valid,
    input  shot_pkg::shot_t              scl_shot,
    input  logic [shot_pkg::POS_W-1:0]   target_xpos,
    input  logic [shot_pkg::POS_W-1:0]   target_ypos,
    output logic                         hit_valid,
    output shot_pkg::hit_t               hit_info
);

    logic [shot_pkg::POS_W-1:0] dx;
    logic [shot_pkg::POS_W-1:0] dy;
    logic                       hit_nxt;

    // unsigned distance without a sign bit
    function automatic logic [shot_pkg::POS_W-1:0] abs_diff(
        input logic [shot_pkg::POS_W-1:0] a,
        input logic [shot_pkg::POS_W-1:0] b
    );
        if (a >= b) begin
            return a - b;
        end
        return b - a;
    endfunction

    assign dx      = abs_diff(scl_shot.xpos, target_xpos);
    assign dy      = abs_diff(scl_shot.ypos, target_ypos);
    assign hit_nxt = (dx <= shot_pkg::TARGET_HALF) && (dy <= shot_pkg::TARGET_HALF);

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_valid <= 1'b0;
        end else begin
            hit_valid <= scl_valid;
        end
    end

    // target sampled here at the same edge as the shot
    always_ff @(posedge clk) begin
        hit_info.xpos <= scl_shot.xpos;
        hit_info.ypos <= scl_shot.ypos;
        hit_info.mode <= scl_shot.mode;
        hit_info.hit  <= hit_nxt;
    end

endmodule

/* shot_score.sv */
// shot score stage
// forwards the judged shot and keeps the saturating score and
// miss count, points per hit depend on the shot's mode

`timescale 1ns/1ps

module shot_score (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hit_valid,
    input  shot_pkg::hit_t                hit_info,
    output logic                          result_valid,
    output shot_pkg::hit_t                result,
    output logic [shot_pkg::SCORE_W-1:0]  score,
    output logic [shot_pkg::MISS_W-1:0]   miss_count
);

    logic [shot_pkg::SCORE_W-1:0] points;
    logic [shot_pkg::SCORE_W:0]   score_sum;  // one carry bit
    logic [shot_pkg::SCORE_W-1:0] score_nxt;
    logic [shot_pkg::MISS_W-1:0]  miss_nxt;

    assign points = (hit_info.mode == shot_pkg::MULTI) ? shot_pkg::MULTI_POINTS
                                                       : shot_pkg::SOLO_POINTS;

    assign score_sum = {1'b0, score} + {1'b0, points};

    always_comb begin
        score_nxt = score;
        miss_nxt  = miss_count;
        if (hit_valid && hit_info.hit) begin
            if (score_sum > {1'b0, shot_pkg::SCORE_MAX}) begin
                score_nxt = shot_pkg::SCORE_MAX;              // clamp at ceiling
            end else begin
                score_nxt = score_sum[shot_pkg::SCORE_W-1:0];
            end
        end else if (hit_valid && (miss_count != shot_pkg::MISS_MAX)) begin
            miss_nxt = miss_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
            score        <= '0;
            miss_count   <= '0;
        end else begin
            result_valid <= hit_valid;
            score        <= score_nxt;   // totals land with result_valid
            miss_count   <= miss_nxt;
        end
    end

    always_ff @(posedge clk) begin
        result <= hit_info;
    end

    // score only moves up between resets
    property p_score_monotonic;
        @(posedge clk) disable iff (rst)
        1'b1 |=> (score >= $past(score));
    endproperty

    a_score_monotonic : assert property (p_score_monotonic)
        else $error("score decreased without reset");

endmodule

/* shot_subsystem.sv */
// shot handling subsystem top
// strobe pipeline of decode, scale, hit check and score,
// four cycles from the sampled press to the result

`timescale 1ns/1ps

module shot_subsystem (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          click,
    input  logic [shot_pkg::POS_W-1:0]    mouse_xpos,
    input  logic [shot_pkg::POS_W-1:0]    mouse_ypos,
    input  shot_pkg::g_mode               game_mode,
    input  logic [shot_pkg::POS_W-1:0]    target_xpos,
    input  logic [shot_pkg::POS_W-1:0]    target_ypos,
    output logic                          result_valid,
    output shot_pkg::hit_t                result,
    output logic [shot_pkg::SCORE_W-1:0]  score,
    output logic [shot_pkg::MISS_W-1:0]   miss_count
);

    logic            cap_valid;
    shot_pkg::shot_t cap_shot;
    logic            scl_valid;
    shot_pkg::shot_t scl_shot;
    logic            hit_valid;
    shot_pkg::hit_t  hit_info;

    shot_decode u_shot_decode (
        .clk        (clk),
        .rst        (rst),
        .click      (click),
        .mouse_xpos (mouse_xpos),
        .mouse_ypos (mouse_ypos),
        .game_mode  (game_mode),
        .cap_valid  (cap_valid),
        .cap_shot   (cap_shot)
    );

    shot_scale u_shot_scale (
        .clk       (clk),
        .rst       (rst),
        .cap_valid (cap_valid),
        .cap_shot  (cap_shot),
        .scl_valid (scl_valid),
        .scl_shot  (scl_shot)
    );

    shot_hit_check u_shot_hit_check (
        .clk         (clk),
        .rst         (rst),
        .scl_valid   (scl_valid),
        .scl_shot    (scl_shot),
        .target_xpos (target_xpos),
        .target_ypos (target_ypos),
        .hit_valid   (hit_valid),
        .hit_info    (hit_info)
    );

    shot_score u_shot_score (
        .clk          (clk),
        .rst          (rst),
        .hit_valid    (hit_valid),
        .hit_info     (hit_info),
        .result_valid (result_valid),
        .result       (result),
        .score        (score),
        .miss_count   (miss_count)
    );

endmodule

/* tb_shot_subsystem.sv */
// testbench for the shot handling subsystem
// directed tests for press detect, solo and multi scaling, hit test,
// pipelined presses and random presses up to score saturation

`timescale 1ns/1ps

module tb_shot_subsystem;

    localparam int PRESS_BUDGET = 3600;   // presses of all tests rounded up
    localparam int CLK_PERIOD   = 8;

    logic                                 clk;
    logic                                 rst;
    logic                                 click;
    logic [shot_pkg::POS_W-1:0]           mouse_xpos;
    logic [shot_pkg::POS_W-1:0]           mouse_ypos;
    shot_pkg::g_mode                      game_mode;
    logic [shot_pkg::POS_W-1:0]           target_xpos;
    logic [shot_pkg::POS_W-1:0]           target_ypos;
    logic                                 result_valid;
    shot_pkg::hit_t                       result;
    logic [shot_pkg::SCORE_W-1:0]         score;
    logic [shot_pkg::MISS_W-1:0]          miss_count;

    int                                   errors;
    int                                   checks;
    int                                   seed;
    logic [shot_pkg::SCORE_W-1:0]         exp_score;
    logic [shot_pkg::MISS_W-1:0]          exp_miss;

    shot_subsystem u_shot_subsystem (
        .clk          (clk),
        .rst          (rst),
        .click        (click),
        .mouse_xpos   (mouse_xpos),
        .mouse_ypos   (mouse_ypos),
        .game_mode    (game_mode),
        .target_xpos  (target_xpos),
        .target_ypos  (target_ypos),
        .result_valid (result_valid),
        .result       (result),
        .score        (score),
        .miss_count   (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // reference model with the band rules per axis and the square hit rule
    function automatic shot_pkg::hit_t model_shot(int x, int y, shot_pkg::g_mode m,
                                                   int tx, int ty);
        shot_pkg::hit_t h;
        int sx;
        int sy;
        int dx;
        int dy;
        sx = x;
        sy = y;
        if (m == shot_pkg::MULTI) begin
            if (x < 155) sx = 0;
            else if (x < 255) sx = x - 120;
            else if (x < 355) sx = x - 100;
            else if (x < 669) sx = x - 50;
            else if (x < 769) sx = x;
            else if (x < 869) sx = x + 20;
            else sx = 1000;
            if (y <= 195) sy = 0;
            else if (y <= 300) sy = y - 85;
            else if (y < 450) sy = y;
            else if (y < 510) sy = y + 40;
            else if (y < 550) sy = 550;
            else sy = 738;
        end
        dx     = (sx > tx) ? sx - tx : tx - sx;
        dy     = (sy > ty) ? sy - ty : ty - sy;
        h.xpos = 10'(sx);
        h.ypos = 10'(sy);
        h.mode = m;
        h.hit  = (dx <= 32) && (dy <= 32);
        return h;
    endfunction

    // saturating totals
    task automatic account(shot_pkg::hit_t h);
        int s;
        s = int'(exp_score) + ((h.mode == shot_pkg::MULTI) ? 20 : 10);
        if (h.hit) exp_score = (s > 65535) ? 16'hffff : 16'(s);
        else if (exp_miss != 8'd255) exp_miss = exp_miss + 8'd1;
    endtask

    task automatic compare_result(shot_pkg::hit_t got, shot_pkg::hit_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0d %0d %0d %0b want %0d %0d %0d %0b",
                     $time, what, got.xpos, got.ypos, got.mode, got.hit,
                     exp.xpos, exp.ypos, exp.mode, exp.hit);
        end
    endtask

    task automatic compare_counts(logic [shot_pkg::SCORE_W-1:0] got_score,
                                  logic [shot_pkg::MISS_W-1:0] got_miss, string what);
        checks++;
        if (got_score !== exp_score || got_miss !== exp_miss) begin
            errors++;
            $display("mismatch at %0t: %s score=%0d miss=%0d, want %0d %0d",
                     $time, what, got_score, got_miss, exp_score, exp_miss);
        end
    endtask

    task automatic reset_dut;
        rst   = 1'b1;
        click = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst       = 1'b0;
        exp_score = '0;
        exp_miss  = '0;
    endtask

    // one press with its result expected 4 edges after the drive
    task automatic press_check(int x, int y, shot_pkg::g_mode m, int tx, int ty, string what);
        shot_pkg::hit_t exp;
        int cycles;
        bit seen;
        exp         = model_shot(x, y, m, tx, ty);
        mouse_xpos  = 10'(x);
        mouse_ypos  = 10'(y);
        game_mode   = m;
        target_xpos = 10'(tx);
        target_ypos = 10'(ty);
        click       = 1'b1;
        seen        = 1'b0;
        cycles      = 0;
        while (!seen && cycles < ((y < 768) ? 4 : 6)) begin
            @(posedge clk);
            #1;
            cycles++;
            click = 1'b0;
            seen  = result_valid;
        end
        if (y >= 768) begin
            if (seen) begin
                errors++;
                $display("%s: off-screen press produced a result", what);
            end
        end else if (!seen) begin
            errors++;
            $display("%s: no result_valid within 4 cycles of the press", what);
        end else begin
            if (cycles != 4) begin
                errors++;
                $display("mismatch at %0t: %s result after %0d cycles", $time, what, cycles);
            end
            account(exp);
            compare_result(result, exp, what);
        end
        compare_counts(score, miss_count, what);
    endtask

    task automatic press_on_target(int x, int y, shot_pkg::g_mode m, string what);
        shot_pkg::hit_t s;
        s = model_shot(x, y, m, 0, 0);
        press_check(x, y, m, s.xpos, s.ypos, what);
    endtask

    task automatic test_reset_and_hold;
        shot_pkg::hit_t exp;
        int pulses;
        reset_dut();
        checks++;
        if (result_valid !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: result_valid high after reset", $time);
        end
        compare_counts(score, miss_count, "after reset");
        exp = model_shot(300, 300, shot_pkg::SOLO, 300, 300);
        mouse_xpos  = 10'd300;
        mouse_ypos  = 10'd300;
        game_mode   = shot_pkg::SOLO;
        target_xpos = 10'd300;
        target_ypos = 10'd300;
        click       = 1'b1;   // held high for the whole window
        pulses      = 0;
        repeat (20) begin
            @(posedge clk);
            #1;
            if (result_valid) begin
                pulses++;
                compare_result(result, exp, "held click");
            end
        end
        click = 1'b0;
        @(posedge clk);
        #1;
        checks++;
        if (pulses != 1) begin
            errors++;
            $display("held click gave %0d results instead of one", pulses);
        end
        account(exp);
        compare_counts(score, miss_count, "held click");
    endtask

    task automatic test_solo;
        press_check(400, 400, shot_pkg::SOLO, 410, 390, "solo hit");
        press_check(50, 700, shot_pkg::SOLO, 410, 390, "solo miss");
    endtask

    task automatic test_multi_bands;
        int xs[12] = '{154, 155, 254, 255, 354, 355, 668, 669, 768, 769, 868, 869};
        int ys[10] = '{195, 196, 300, 301, 449, 450, 509, 510, 549, 550};
        foreach (xs[i]) press_on_target(xs[i], 350, shot_pkg::MULTI, "multi x band");
        foreach (ys[i]) press_on_target(500, ys[i], shot_pkg::MULTI, "multi y band");
        press_on_target(1023, 767, shot_pkg::MULTI, "multi far corner");
    endtask

    task automatic test_off_screen;
        press_check(300, 768, shot_pkg::SOLO, 300, 768, "off screen 768");
        press_check(300, 1000, shot_pkg::MULTI, 300, 1000, "off screen 1000");
    endtask

    // back to back presses with the mode flipped in the gap cycles
    task automatic test_pipelined;
        shot_pkg::hit_t expq[$];
        shot_pkg::hit_t exp;
        int xs[4] = '{520, 560, 540, 480};
        int ys[4] = '{400, 420, 430, 390};
        shot_pkg::g_mode ms[4] = '{shot_pkg::MULTI, shot_pkg::SOLO,
                                   shot_pkg::MULTI, shot_pkg::SOLO};
        int got;
        target_xpos = 10'd500;
        target_ypos = 10'd400;
        got         = 0;
        for (int step = 0; step < 14; step++) begin
            if (step < 8 && step % 2 == 0) begin
                mouse_xpos = 10'(xs[step / 2]);
                mouse_ypos = 10'(ys[step / 2]);
                game_mode  = ms[step / 2];
                click      = 1'b1;
                expq.push_back(model_shot(xs[step / 2], ys[step / 2], ms[step / 2], 500, 400));
            end else begin
                click      = 1'b0;
                game_mode  = (game_mode == shot_pkg::SOLO) ? shot_pkg::MULTI : shot_pkg::SOLO;
                mouse_xpos = 10'd10;
            end
            @(posedge clk);
            #1;
            if (result_valid && expq.size() == 0) begin
                errors++;
                $display("pipelined presses: result_valid with no press outstanding");
            end else if (result_valid) begin
                exp = expq.pop_front();
                got++;
                account(exp);
                compare_result(result, exp, "pipelined");
                compare_counts(score, miss_count, "pipelined");
            end
        end
        checks++;
        if (got != 4) begin
            errors++;
            $display("pipelined presses gave %0d results instead of 4", got);
        end
    endtask

    task automatic random_press(string what);
        shot_pkg::hit_t s;
        shot_pkg::g_mode m;
        int x;
        int y;
        int tx;
        int ty;
        x  = {$random(seed)} % 1024;
        y  = {$random(seed)} % 768;
        m  = shot_pkg::g_mode'({$random(seed)} % 2);
        s  = model_shot(x, y, m, 0, 0);
        tx = int'(s.xpos) + ($random(seed) % 41);   // near the scaled point
        ty = int'(s.ypos) + ($random(seed) % 41);
        tx = (tx < 0) ? 0 : ((tx > 1023) ? 1023 : tx);
        ty = (ty < 0) ? 0 : ((ty > 1023) ? 1023 : ty);
        press_check(x, y, m, tx, ty, what);
    endtask

    task automatic test_random;
        repeat (100) random_press("random");
        // multi hits until the ceiling is a few hits away
        while (exp_score < 16'd65335) begin
            press_on_target(500, 400, shot_pkg::MULTI, "preload");
        end
        repeat (100) random_press("random saturating");
        checks++;
        if (exp_score != 16'hffff) begin
            errors++;
            $display("random presses never drove the score to its ceiling");
        end
    endtask

    // watchdog allows 20 cycles per press plus margin
    initial begin
        #((PRESS_BUDGET * 20 + 500) * CLK_PERIOD);
        $display("timeout: run stopped at %0t before the tests finished", $time);
        $display("Regression failed");
        $finish;
    end

    initial begin
        errors      = 0;
        checks      = 0;
        seed        = 32'h763fd882;
        rst         = 1'b1;
        click       = 1'b0;
        mouse_xpos  = '0;
        mouse_ypos  = '0;
        game_mode   = shot_pkg::SOLO;
        target_xpos = '0;
        target_ypos = '0;
        exp_score   = '0;
        exp_miss    = '0;
        test_reset_and_hold();
        test_solo();
        test_multi_bands();
        test_off_screen();
        test_pipelined();
        test_random();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* project.f */
shot_pkg.sv
shot_decode.sv
shot_scale.sv
shot_hit_check.sv
shot_score.sv
shot_subsystem.sv
tb_shot_subsystem.sv
